/* verilog/cmp_rx_pkg.sv */
package cmp_rx_pkg;

  //----------------------------------------------------------------------
  // Link word and frame types
  //----------------------------------------------------------------------
  typedef logic [15:0] rx_word_t;     // One decoded 8b/10b word
  typedef logic [1:0]  ctrl_pair_t;   // Per-byte flags, bit 0 is the low byte
  typedef logic [1:0]  word_idx_t;    // 0 = K word, 1..3 = data
  typedef logic [47:0] frame_data_t;  // {word3, word2, word1}
  typedef logic [15:0] char_cnt_t;    // Character error count
  typedef logic [7:0]  link_cnt_t;    // Link loss count

  // Assembler FSM
  typedef enum logic {
    ASM_IDLE,     // Waiting for a K word
    ASM_COLLECT   // K word seen, data words expected
  } asm_state_t;

  //----------------------------------------------------------------------
  // Frame constants
  //----------------------------------------------------------------------
  localparam ctrl_pair_t K_LOW_ONLY = 2'b01;   // Low byte K, high byte data

  // Bits 4:1 of the K byte, so 1C 3C 5C 7C 9C BC DC FD all pass
  localparam logic [3:0] EOF_MARK_BITS = 4'hE;

  localparam logic [7:0] LTNCY_CHAR = 8'hFC;   // K28.7 flags a latency trigger

  // Counter limits
  localparam char_cnt_t CHAR_CNT_MAX   = 16'hFFFE;
  localparam link_cnt_t LINK_CNT_MAX   = 8'hFE;
  localparam link_cnt_t LINK_BAD_LIMIT = 8'd127;

endpackage

/* verilog/frame_aligner.sv */
`timescale 1ns/10ps

module frame_aligner (
  input  logic                   CMP_RX_CLK160,
  input  logic                   cmp_rx_resetdone,
  input  logic                   ttc_resync,
  input  cmp_rx_pkg::rx_word_t   rx_data,
  input  cmp_rx_pkg::ctrl_pair_t rx_isk,
  input  cmp_rx_pkg::ctrl_pair_t rx_notintable,
  input  cmp_rx_pkg::ctrl_pair_t rx_disperr,
  input  logic                   rx_lossofsync,
  output cmp_rx_pkg::rx_word_t   word,
  output cmp_rx_pkg::ctrl_pair_t word_isk,
  output cmp_rx_pkg::ctrl_pair_t word_notintable,
  output cmp_rx_pkg::ctrl_pair_t word_disperr,
  output logic                   word_los,
  output cmp_rx_pkg::word_idx_t  word_idx,
  output logic                   word_vld
);
  import cmp_rx_pkg::*;

  logic      k_start;    // Frame start on this input word
  logic      in_frame;   // Previous word left data slots open
  word_idx_t idx_nxt;

  assign k_start  = (rx_isk == K_LOW_ONLY);
  assign in_frame = word_vld && (word_idx != 2'd3);
  assign idx_nxt  = k_start ? 2'd0 : word_idx + 2'd1;  // K word restarts the count

  //----------------------------------------------------------------------
  // Position tag
  //----------------------------------------------------------------------
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      word_vld <= 1'b0;
      word_idx <= 2'd0;
    end else if (ttc_resync) begin
      word_vld <= 1'b0;       // Drop any open frame
      word_idx <= 2'd0;
    end else begin
      word_vld <= k_start || in_frame;   // Idle words between frames stay untagged
      word_idx <= idx_nxt;
    end
  end

  // Word and flags ride along with the tag
  always_ff @(posedge CMP_RX_CLK160) begin
    word            <= rx_data;
    word_isk        <= rx_isk;
    word_notintable <= rx_notintable;
    word_disperr    <= rx_disperr;
    word_los        <= rx_lossofsync;
  end

  // Data slots only ever step up by one from the previous tagged word
  a_idx_step: assert property (
    @(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
    (word_vld && (word_idx != 2'd0)) |->
      ($past(word_vld) && (word_idx == word_idx_t'($past(word_idx) + 2'd1)))
  );

endmodule

/* verilog/frame_assembler.sv */
`timescale 1ns/10ps

module frame_assembler (
  input  logic                    CMP_RX_CLK160,
  input  logic                    cmp_rx_resetdone,
  input  logic                    ttc_resync,
  input  cmp_rx_pkg::rx_word_t    word,
  input  cmp_rx_pkg::ctrl_pair_t  word_isk,
  input  cmp_rx_pkg::ctrl_pair_t  word_notintable,
  input  logic                    word_los,
  input  cmp_rx_pkg::word_idx_t   word_idx,
  input  logic                    word_vld,
  output cmp_rx_pkg::frame_data_t rcv_data,
  output cmp_rx_pkg::rx_word_t    rcv_kchar,
  output logic                    ltncy_trig,
  output logic [3:1]              nonzero_word,
  output logic                    frame_valid,
  output logic                    frame_end,
  output logic                    frame_good
);
  import cmp_rx_pkg::*;

  asm_state_t state;
  rx_word_t   k_reg;     // K word of the open frame
  rx_word_t   w1_reg;
  rx_word_t   w2_reg;
  logic       frm_ok;    // No fault seen so far in the open frame
  logic       k_in;
  logic       d_in;
  logic       last_in;   // Word 3 of an open frame
  logic       k_ok;
  logic       d_ok;

  assign k_in    = word_vld && (word_idx == 2'd0);
  assign d_in    = word_vld && (word_idx != 2'd0);
  assign last_in = (state == ASM_COLLECT) && d_in && (word_idx == 2'd3);

  // Per-word quality checks
  assign k_ok = (word[4:1] == EOF_MARK_BITS) && (word_notintable == 2'b00) && !word_los;
  assign d_ok = (word_isk == 2'b00) && (word_notintable == 2'b00) && !word_los;

  //----------------------------------------------------------------------
  // Assembler FSM and frame verdict
  //----------------------------------------------------------------------
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      state       <= ASM_IDLE;
      frm_ok      <= 1'b0;
      frame_valid <= 1'b0;
      frame_end   <= 1'b0;
      frame_good  <= 1'b0;
      ltncy_trig  <= 1'b0;
    end else if (ttc_resync) begin
      state       <= ASM_IDLE;
      frm_ok      <= 1'b0;
      frame_valid <= 1'b0;
      frame_end   <= 1'b0;
      frame_good  <= 1'b0;
      ltncy_trig  <= 1'b0;
    end else begin
      frame_valid <= 1'b0;   // Pulses
      frame_end   <= 1'b0;
      frame_good  <= 1'b0;
      case (state)
        ASM_IDLE: begin
          if (k_in) begin
            state  <= ASM_COLLECT;
            frm_ok <= k_ok;
          end
        end
        ASM_COLLECT: begin
          if (k_in) begin
            frame_end <= 1'b1;   // Cut short by a new K word, which opens the next frame
            frm_ok    <= k_ok;
          end else if (!word_vld) begin
            frame_end <= 1'b1;   // Cut short by an untagged word
            state     <= ASM_IDLE;
          end else if (last_in) begin
            frame_valid <= 1'b1;
            frame_end   <= 1'b1;
            frame_good  <= frm_ok && d_ok;
            ltncy_trig  <= (k_reg[7:0] == LTNCY_CHAR);
            state       <= ASM_IDLE;
          end else begin
            frm_ok <= frm_ok && d_ok;
          end
        end
        default: state <= ASM_IDLE;
      endcase
    end
  end

  // Word capture, outputs hold until the next complete frame
  always_ff @(posedge CMP_RX_CLK160) begin
    if (k_in) k_reg <= word;
    if (d_in && (word_idx == 2'd1)) w1_reg <= word;
    if (d_in && (word_idx == 2'd2)) w2_reg <= word;
    if (last_in) begin
      rcv_data     <= {word, w2_reg, w1_reg};
      rcv_kchar    <= k_reg;
      nonzero_word <= {|word, |w2_reg, |w1_reg};
    end
  end

  // A finished frame is always word 3 of the previous cycle and also ends the frame
  a_valid_end: assert property (
    @(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
    frame_valid |-> (frame_end && $past(word_vld && (word_idx == 2'd3)))
  );

endmodule

/* verilog/link_monitor.sv */
`timescale 1ns/10ps

module link_monitor #(
  parameter int unsigned link_good_frames = 16   // Good frames in a row for link up
) (
  input  logic                   CMP_RX_CLK160,
  input  logic                   cmp_rx_resetdone,
  input  logic                   ttc_resync,
  input  logic                   frame_end,
  input  logic                   frame_good,
  input  logic                   word_vld,
  input  cmp_rx_pkg::ctrl_pair_t word_notintable,
  input  cmp_rx_pkg::ctrl_pair_t word_disperr,
  input  logic                   force_error,
  output logic                   link_good,
  output logic                   link_had_err,
  output logic                   link_bad,
  output cmp_rx_pkg::link_cnt_t  errcount,
  output cmp_rx_pkg::char_cnt_t  notintablecount,
  output cmp_rx_pkg::char_cnt_t  disperrcount
);
  import cmp_rx_pkg::*;

  localparam logic [7:0] GOOD_RUN = 8'(link_good_frames);

  logic [7:0] run_cnt;     // Good frames in a row, stops at GOOD_RUN
  logic [7:0] run_nxt;
  logic       ever_good;   // Link has been up since the last clear
  logic       link_err;    // Sticky link loss
  logic [1:0] fe_sync;     // force_error synchronizer
  logic       fe_dly;
  logic       err_inj;
  logic       link_loss;
  logic [1:0] err_add;     // Loss and injection in one cycle count twice

  function automatic char_cnt_t sat_inc(input char_cnt_t cnt, input logic hit);
    if (hit && (cnt != CHAR_CNT_MAX)) return cnt + 16'd1;
    return cnt;
  endfunction

  always_comb begin
    run_nxt = run_cnt;
    if (frame_end) begin
      if (!frame_good) run_nxt = 8'd0;                         // Any bad frame restarts the run
      else if (run_cnt != GOOD_RUN) run_nxt = run_cnt + 8'd1;
    end
  end

  assign link_good    = (run_cnt == GOOD_RUN);
  assign link_loss    = frame_end && !frame_good && link_good;
  assign err_inj      = fe_dly && !fe_sync[1];           // Falling edge after sync
  assign err_add      = {1'b0, link_loss} + {1'b0, err_inj};
  assign link_had_err = link_err || !ever_good;          // Also high until first link up
  assign link_bad     = (errcount > LINK_BAD_LIMIT);

  //----------------------------------------------------------------------
  // Error injection input, asynchronous to the link
  //----------------------------------------------------------------------
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      fe_sync <= 2'b00;
      fe_dly  <= 1'b0;
    end else begin
      fe_sync <= {fe_sync[0], force_error};
      fe_dly  <= fe_sync[1];
    end
  end

  //----------------------------------------------------------------------
  // Link state and counters
  //----------------------------------------------------------------------
  always_ff @(posedge CMP_RX_CLK160 or negedge cmp_rx_resetdone) begin
    if (!cmp_rx_resetdone) begin
      run_cnt         <= 8'd0;
      ever_good       <= 1'b0;
      link_err        <= 1'b0;
      errcount        <= '0;
      notintablecount <= '0;
      disperrcount    <= '0;
    end else if (ttc_resync) begin
      run_cnt         <= 8'd0;
      ever_good       <= 1'b0;
      link_err        <= 1'b0;
      errcount        <= '0;
      notintablecount <= '0;
      disperrcount    <= '0;
    end else begin
      run_cnt <= run_nxt;
      if (run_nxt == GOOD_RUN) ever_good <= 1'b1;
      if (link_loss) link_err <= 1'b1;   // Was up, then dropped
      if (err_add != 2'd0) begin         // Both sources count as a lost link
        if (errcount >= LINK_CNT_MAX - link_cnt_t'(err_add)) begin
          errcount <= LINK_CNT_MAX;
        end else begin
          errcount <= errcount + link_cnt_t'(err_add);
        end
      end
      if (word_vld) begin                // Only words inside a frame count
        notintablecount <= sat_inc(notintablecount, |word_notintable);
        disperrcount    <= sat_inc(disperrcount, |word_disperr);
      end
    end
  end

  a_errcount_sat: assert property (
    @(posedge CMP_RX_CLK160) disable iff (!cmp_rx_resetdone)
    errcount <= LINK_CNT_MAX
  );

endmodule

/* verilog/cmp_fiber_rx.sv */
`timescale 1ns/10ps

module cmp_fiber_rx #(
  parameter int unsigned link_good_frames = 16
) (
  input  logic                    CMP_RX_CLK160,
  input  logic                    cmp_rx_resetdone,
  input  logic                    ttc_resync,
  input  cmp_rx_pkg::rx_word_t    rx_data,
  input  cmp_rx_pkg::ctrl_pair_t  rx_isk,
  input  cmp_rx_pkg::ctrl_pair_t  rx_notintable,
  input  cmp_rx_pkg::ctrl_pair_t  rx_disperr,
  input  logic                    rx_lossofsync,
  input  logic                    force_error,
  output cmp_rx_pkg::frame_data_t rcv_data,
  output cmp_rx_pkg::rx_word_t    rcv_kchar,
  output logic                    ltncy_trig,
  output logic [3:1]              nonzero_word,
  output logic                    frame_valid,
  output logic                    link_good,
  output logic                    link_had_err,
  output logic                    link_bad,
  output cmp_rx_pkg::link_cnt_t   errcount,
  output cmp_rx_pkg::char_cnt_t   notintablecount,
  output cmp_rx_pkg::char_cnt_t   disperrcount
);
  import cmp_rx_pkg::*;

  // Tagged word stream
  rx_word_t   word;
  ctrl_pair_t word_isk;
  ctrl_pair_t word_notintable;
  ctrl_pair_t word_disperr;
  logic       word_los;
  word_idx_t  word_idx;
  logic       word_vld;

  // Frame verdict
  logic frame_end;
  logic frame_good;

  frame_aligner u_aligner (
    .CMP_RX_CLK160    (CMP_RX_CLK160),
    .cmp_rx_resetdone (cmp_rx_resetdone),
    .ttc_resync       (ttc_resync),
    .rx_data          (rx_data),
    .rx_isk           (rx_isk),
    .rx_notintable    (rx_notintable),
    .rx_disperr       (rx_disperr),
    .rx_lossofsync    (rx_lossofsync),
    .word             (word),
    .word_isk         (word_isk),
    .word_notintable  (word_notintable),
    .word_disperr     (word_disperr),
    .word_los         (word_los),
    .word_idx         (word_idx),
    .word_vld         (word_vld)
  );

  frame_assembler u_assembler (
    .CMP_RX_CLK160    (CMP_RX_CLK160),
    .cmp_rx_resetdone (cmp_rx_resetdone),
    .ttc_resync       (ttc_resync),
    .word             (word),
    .word_isk         (word_isk),
    .word_notintable  (word_notintable),
    .word_los         (word_los),
    .word_idx         (word_idx),
    .word_vld         (word_vld),
    .rcv_data         (rcv_data),
    .rcv_kchar        (rcv_kchar),
    .ltncy_trig       (ltncy_trig),
    .nonzero_word     (nonzero_word),
    .frame_valid      (frame_valid),
    .frame_end        (frame_end),
    .frame_good       (frame_good)
  );

  link_monitor #(
    .link_good_frames (link_good_frames)
  ) u_monitor (
    .CMP_RX_CLK160    (CMP_RX_CLK160),
    .cmp_rx_resetdone (cmp_rx_resetdone),
    .ttc_resync       (ttc_resync),
    .frame_end        (frame_end),
    .frame_good       (frame_good),
    .word_vld         (word_vld),
    .word_notintable  (word_notintable),
    .word_disperr     (word_disperr),
    .force_error      (force_error),
    .link_good        (link_good),
    .link_had_err     (link_had_err),
    .link_bad         (link_bad),
    .errcount         (errcount),
    .notintablecount  (notintablecount),
    .disperrcount     (disperrcount)
  );

endmodule

/* include/cmp_rx_model.svh */
`ifndef CMP_RX_MODEL_SVH
`define CMP_RX_MODEL_SVH

// Frame level model of the receiver, fed one input word at a time
// Needs cmp_rx_pkg imported where it is included
int unsigned good_frames;     // Same value as link_good_frames
int          open_idx;        // Last index of the open frame, -1 when none
bit          frame_ok;
rx_word_t    k_word;
rx_word_t    data_w1;
rx_word_t    data_w2;
frame_data_t exp_data;        // Last complete frame
rx_word_t    exp_kchar;
bit          exp_ltncy;
bit [3:1]    exp_nz;
int unsigned good_run;
int unsigned exp_errcount;
int unsigned exp_nit_cnt;
int unsigned exp_disp_cnt;
bit          exp_link_good;
bit          exp_ever_good;
bit          exp_link_err;

// Reset or ttc_resync
function void clear_model();
  open_idx      = -1;
  frame_ok      = 0;
  good_run      = 0;
  exp_errcount  = 0;
  exp_nit_cnt   = 0;
  exp_disp_cnt  = 0;
  exp_link_good = 0;
  exp_ever_good = 0;
  exp_link_err  = 0;
endfunction

function void add_link_error();
  if (exp_errcount < LINK_CNT_MAX) exp_errcount++;
endfunction

function void close_frame(input bit good);
  if (!good) begin
    if (exp_link_good) begin
      exp_link_err = 1;
      add_link_error();
    end
    good_run = 0;
  end else if (good_run < good_frames) begin
    good_run++;
  end
  exp_link_good = (good_run == good_frames);
  exp_ever_good = exp_ever_good || exp_link_good;
endfunction

function bit expect_had_err();
  return exp_link_err || !exp_ever_good;
endfunction

function bit expect_link_bad();
  return exp_errcount > LINK_BAD_LIMIT;
endfunction

// Returns 1 when the word completes a frame
function bit push_word(input rx_word_t d, input ctrl_pair_t isk, input ctrl_pair_t nit,
                       input ctrl_pair_t disp, input bit los);
  bit is_k;
  bit done;
  is_k = (isk == K_LOW_ONLY);
  done = 0;
  if (is_k || (open_idx >= 0)) begin
    if ((nit != 2'b00) && (exp_nit_cnt < CHAR_CNT_MAX)) exp_nit_cnt++;
    if ((disp != 2'b00) && (exp_disp_cnt < CHAR_CNT_MAX)) exp_disp_cnt++;
  end
  if (is_k) begin
    if (open_idx >= 0) close_frame(0);
    open_idx = 0;
    k_word   = d;
    frame_ok = (d[4:1] == EOF_MARK_BITS) && (nit == 2'b00) && !los;
  end else if (open_idx >= 0) begin
    open_idx++;
    frame_ok = frame_ok && (isk == 2'b00) && (nit == 2'b00) && !los;
    if (open_idx == 1) begin
      data_w1 = d;
    end else if (open_idx == 2) begin
      data_w2 = d;
    end else begin
      exp_data  = {d, data_w2, data_w1};
      exp_kchar = k_word;
      exp_ltncy = (k_word[7:0] == LTNCY_CHAR);
      exp_nz    = {|d, |data_w2, |data_w1};
      close_frame(frame_ok);
      open_idx = -1;
      done     = 1;
    end
  end
  return done;
endfunction

`endif

/* testbench/cmp_fiber_rx_tb.sv */
`timescale 1ns/10ps

module cmp_fiber_rx_tb;
  import cmp_rx_pkg::*;
  `include "cmp_rx_model.svh"

  localparam int unsigned GOOD_FRAMES   = 4;    // Short run so the link toggles often
  localparam int          FRAME_TIMEOUT = 10;   // Cycles to wait for frame_valid
  localparam int          N_ACTIONS     = 800;

  logic        CMP_RX_CLK160;
  logic        cmp_rx_resetdone;
  logic        ttc_resync;
  rx_word_t    rx_data;
  ctrl_pair_t  rx_isk;
  ctrl_pair_t  rx_notintable;
  ctrl_pair_t  rx_disperr;
  logic        rx_lossofsync;
  logic        force_error;
  frame_data_t rcv_data;
  rx_word_t    rcv_kchar;
  logic        ltncy_trig;
  logic [3:1]  nonzero_word;
  logic        frame_valid;
  logic        link_good;
  logic        link_had_err;
  logic        link_bad;
  link_cnt_t   errcount;
  char_cnt_t   notintablecount;
  char_cnt_t   disperrcount;

  bit [1:0]    done_pipe;    // Model frame closes, two cycles ahead of frame_valid
  int unsigned sel;

  cmp_fiber_rx #(.link_good_frames(GOOD_FRAMES)) dut_i (.*);

  always #4 CMP_RX_CLK160 = ~CMP_RX_CLK160;   // 125 MHz stand-in

  //----------------------------------------------------------------------
  // Checks
  //----------------------------------------------------------------------
  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %0h actual %0h", name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_link(input string tag);
    check_val({tag, " link_good"}, exp_link_good, link_good);
    check_val({tag, " link_had_err"}, expect_had_err(), link_had_err);
    check_val({tag, " errcount"}, exp_errcount, errcount);
    check_val({tag, " link_bad"}, expect_link_bad(), link_bad);
  endtask

  task automatic check_chars(input string tag);
    check_val({tag, " notintablecount"}, exp_nit_cnt, notintablecount);
    check_val({tag, " disperrcount"}, exp_disp_cnt, disperrcount);
  endtask

  //----------------------------------------------------------------------
  // Stimulus
  //----------------------------------------------------------------------
  function automatic ctrl_pair_t rand_flags(input int unsigned one_in);
    if ($urandom % one_in == 0) return ctrl_pair_t'($urandom_range(3, 1));
    return 2'b00;
  endfunction

  // One word, 1 ns after the edge, model fed in step
  task automatic drive_word(input rx_word_t d, input ctrl_pair_t isk, input ctrl_pair_t nit,
                            input ctrl_pair_t disp, input logic los);
    @(posedge CMP_RX_CLK160);
    #1;
    check_val("frame_valid", done_pipe[1], frame_valid);   // No missing or extra frames
    rx_data       = d;
    rx_isk        = isk;
    rx_notintable = nit;
    rx_disperr    = disp;
    rx_lossofsync = los;
    done_pipe     = {done_pipe[0], push_word(d, isk, nit, disp, los)};
  endtask

  // Idle word, never a frame start
  task automatic drive_idle();
    ctrl_pair_t isk;
    isk = 2'b00;
    if ($urandom % 4 == 0) isk = {1'b1, ($urandom % 2 == 1)};   // 10 or 11
    drive_word(16'($urandom), isk, rand_flags(6), rand_flags(6), 1'b0);
  endtask

  // K word plus n_data data words; fewer than 3 leaves the frame open
  task automatic drive_frame(input bit bad, input int n_data);
    logic [7:0] kb;
    rx_word_t   d;
    ctrl_pair_t isk;
    ctrl_pair_t nit;
    logic       los;
    int         i;
    kb  = {3'($urandom), 5'b11100};   // 1C .. FC
    nit = 2'b00;
    los = 1'b0;
    if (bad) begin
      if ($urandom % 3 == 0) kb = 8'($urandom);   // EOF mark likely wrong
      nit = rand_flags(3);
      los = ($urandom % 6 == 0);
    end
    drive_word({8'($urandom), kb}, K_LOW_ONLY, nit, rand_flags(8), los);
    for (i = 1; i <= n_data; i++) begin
      d   = ($urandom % 4 == 0) ? 16'h0000 : 16'($urandom);   // Some empty words
      isk = 2'b00;
      nit = 2'b00;
      los = 1'b0;
      if (bad) begin
        if ($urandom % 4 == 0) isk = {1'b1, ($urandom % 2 == 1)};
        nit = rand_flags(3);
        los = ($urandom % 8 == 0);
      end
      drive_word(d, isk, nit, rand_flags(8), los);
    end
  endtask

  // Idle until frame_valid, then compare frame, counters and link state
  task automatic check_frame();
    int n;
    n = 0;
    do begin
      drive_idle();
      n++;
    end while (!frame_valid && (n < FRAME_TIMEOUT));
    if (!frame_valid) begin
      $display("No frame arrived within %0d cycles after its last word", FRAME_TIMEOUT);
      $display("SOME TESTS FAILED");
      $fatal(1, "Frame timeout");
    end else begin
      check_val("rcv_data", exp_data, rcv_data);
      check_val("rcv_kchar", exp_kchar, rcv_kchar);
      check_val("nonzero_word", exp_nz, nonzero_word);
      check_val("ltncy_trig", exp_ltncy, ltncy_trig);
      check_chars("frame");
      drive_idle();   // Link state lags frame_end by one cycle
      check_link("frame");
    end
  endtask

  // force_error pulse, counted on its falling edge
  task automatic inject_error();
    drive_idle();
    force_error = 1'b1;
    drive_idle();
    drive_idle();
    force_error = 1'b0;
    repeat (5) drive_idle();   // Sync plus edge detect
    add_link_error();
    check_val("inject errcount", exp_errcount, errcount);
    check_val("inject link_bad", expect_link_bad(), link_bad);
  endtask

  task automatic resync_link();
    drive_idle();
    ttc_resync = 1'b1;
    drive_idle();
    ttc_resync = 1'b0;
    clear_model();
    drive_idle();
    drive_idle();
    check_link("resync");
    check_chars("resync");
  endtask

  //----------------------------------------------------------------------
  // Main sequence
  //----------------------------------------------------------------------
  initial begin
    CMP_RX_CLK160    = 1'b0;
    cmp_rx_resetdone = 1'b0;
    ttc_resync       = 1'b0;
    rx_data          = '0;
    rx_isk           = 2'b00;
    rx_notintable    = 2'b00;
    rx_disperr       = 2'b00;
    rx_lossofsync    = 1'b0;
    force_error      = 1'b0;
    done_pipe        = 2'b00;
    void'($urandom(44989));
    good_frames = GOOD_FRAMES;
    clear_model();

    repeat (16) @(posedge CMP_RX_CLK160);
    #1;
    cmp_rx_resetdone = 1'b1;
    check_val("reset frame_valid", 1'b0, frame_valid);
    check_val("reset ltncy_trig", 1'b0, ltncy_trig);
    check_link("reset");
    check_chars("reset");

    for (int a = 0; a < N_ACTIONS; a++) begin
      sel = $urandom % 100;
      if (sel < 50) begin
        drive_frame(1'b0, 3);
        check_frame();
      end else if (sel < 65) begin
        drive_frame(1'b1, 3);
        check_frame();
      end else if (sel < 75) begin
        drive_frame(($urandom % 2 == 1), $urandom % 3);   // Cut short by the next K
        drive_frame(1'b0, 3);
        check_frame();
      end else if (sel < 83) begin
        inject_error();
      end else if (sel < 85) begin
        resync_link();
      end else begin
        repeat ($urandom_range(4, 1)) drive_idle();
      end
    end

    // Push errcount through the link_bad limit into saturation at 254
    repeat (260) inject_error();
    check_val("final errcount", 8'd254, errcount);
    check_val("final link_bad", 1'b1, link_bad);
    resync_link();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* compile.f */
verilog/cmp_rx_pkg.sv
verilog/frame_aligner.sv
verilog/frame_assembler.sv
verilog/link_monitor.sv
verilog/cmp_fiber_rx.sv
+incdir+include
testbench/cmp_fiber_rx_tb.sv
